// ==== compile.f ====
hdl/mem_pkg.sv
hdl/bus_pkg.sv
hdl/dbus_if.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/dev_regs.sv
hdl/dbus_router.sv
hdl/mem_subsys_top.sv
verification/tb_mem_subsys.sv

// ==== verification/tb_mem_subsys.sv ====
/* Directed testbench for the memory subsystem top: none, RAM, device,
   unmapped and back-pressure accesses checked against a byte shadow model. */
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 20;

  logic                       clk;
  logic                       rst;
  logic                       i_executed_req;
  mem_pkg::mem_action_t       i_memaction;
  mem_pkg::funct3_t           i_funct3;
  logic [bus_pkg::ADDR_W-1:0] i_addr;
  logic [mem_pkg::XLEN-1:0]   i_wdata;
  logic                       i_memoryed_ack;
  logic                       o_memoryed_req;
  logic [mem_pkg::XLEN-1:0]   o_rdata;
  logic                       o_bus_err;

  // shadow of the low 4 KB of RAM, wraps like the array
  logic [7:0]  shadow [0:4095];
  logic [31:0] lfsr_q = 32'hf56c_0c0a;
  int          cyc = 0;
  int          issue_cyc;
  int          data_errs = 0;
  int          bit_errs = 0;
  int          lat_errs = 0;
  int          timeouts = 0;

  mem_subsys_top DUT (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .i_memaction    (i_memaction),
    .i_funct3       (i_funct3),
    .i_addr         (i_addr),
    .i_wdata        (i_wdata),
    .i_memoryed_ack (i_memoryed_ack),
    .o_memoryed_req (o_memoryed_req),
    .o_rdata        (o_rdata),
    .o_bus_err      (o_bus_err)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // free-running edge count, timer reference
  always @(posedge clk) cyc <= cyc + 1;

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // aligned address somewhere in the RAM region
  function automatic logic [63:0] rand_ram_addr(input logic [1:0] w);
    return bus_pkg::RAM_BASE | (rand_bits(28) & ~((64'd1 << w) - 64'd1));
  endfunction

  // load result built byte by byte from the shadow
  function automatic logic [63:0] expected_load(input logic [63:0] addr,
                                                input mem_pkg::funct3_t f3);
    logic [63:0] e;
    int          n;
    e = '0;
    n = 1 << f3[1:0];
    for (int i = 0; i < n; i++) e[i*8 +: 8] = shadow[addr[11:0] + i];
    // signed: copy the top stored bit upward
    if (!f3[2] && e[n*8-1]) begin
      for (int i = n * 8; i < 64; i++) e[i] = 1'b1;
    end
    return e;
  endfunction

  task automatic check_data(input string name, input logic [mem_pkg::XLEN-1:0] got,
                            input logic [mem_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      data_errs++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      lat_errs++;
      $display("ERR o_memoryed_req latency got %0h exp %0h", got, exp);
    end
  endtask

  // one-cycle op from execute, issue edge recorded
  task automatic issue(input mem_pkg::mem_action_t act, input mem_pkg::funct3_t f3,
                       input logic [63:0] addr, input logic [63:0] wdata);
    @(posedge clk);
    i_executed_req <= 1'b1;
    i_memaction    <= act;
    i_funct3       <= f3;
    i_addr         <= addr;
    i_wdata        <= wdata;
    @(posedge clk);
    issue_cyc = cyc;
    i_executed_req <= 1'b0;
  endtask

  // wait for writeback req, hold it for a while, then ack
  task automatic await_and_ack(input int hold, output int lat,
                               output logic [63:0] rd, output logic er);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!o_memoryed_req && lat < TIMEOUT);
    rd = o_rdata;
    er = o_bus_err;
    if (!o_memoryed_req) begin
      timeouts++;
      $display("o_memoryed_req did not rise within %0d cycles", TIMEOUT);
    end else begin
      // back-pressure, outputs must not move
      repeat (hold) begin
        @(negedge clk);
        check_err("o_memoryed_req held", o_memoryed_req, 1'b1);
        check_data("o_rdata held", o_rdata, rd);
        check_err("o_bus_err held", o_bus_err, er);
      end
      @(posedge clk);
      i_memoryed_ack <= 1'b1;
      @(posedge clk);
      i_memoryed_ack <= 1'b0;
    end
  endtask

  task automatic run_op(input mem_pkg::mem_action_t act, input mem_pkg::funct3_t f3,
                        input logic [63:0] addr, input logic [63:0] wdata,
                        input int exp_lat, input int hold,
                        output logic [63:0] rd, output logic er);
    int lat;
    issue(act, f3, addr, wdata);
    await_and_ack(hold, lat, rd, er);
    check_latency(lat, exp_lat);
  endtask

  task automatic ram_store(input logic [1:0] w, input logic [63:0] addr,
                           input logic [63:0] data);
    logic [63:0] rd;
    logic        er;
    run_op(mem_pkg::MEM_ACTION_STORE, {1'b0, w}, addr, data, 3, 0, rd, er);
    check_data("o_rdata store", rd, '0);
    check_err("o_bus_err", er, 1'b0);
    for (int i = 0; i < (1 << w); i++) shadow[addr[11:0] + i] = data[i*8 +: 8];
  endtask

  task automatic ram_load(input mem_pkg::funct3_t f3, input logic [63:0] addr, input int hold);
    logic [63:0] rd;
    logic        er;
    run_op(mem_pkg::MEM_ACTION_LOAD, f3, addr, '0, 3, hold, rd, er);
    check_data("o_rdata", rd, expected_load(addr, f3));
    check_err("o_bus_err", er, 1'b0);
  endtask

  task automatic test_none();
    logic [63:0] rd;
    logic        er;
    run_op(mem_pkg::MEM_ACTION_NONE, 3'b000, '0, '0, 1, 2, rd, er);
    check_err("o_bus_err", er, 1'b0);
    // drops the cycle after ack
    @(negedge clk);
    check_err("o_memoryed_req after ack", o_memoryed_req, 1'b0);
  endtask

  task automatic test_ram_random();
    logic [1:0]  w;
    logic [63:0] addr;
    for (int k = 0; k < 16; k++) begin
      w    = rand_bits(2);
      addr = rand_ram_addr(w);
      ram_store(w, addr, rand_bits(64));
      // lbu, lhu, lwu, ld
      ram_load((w == 2'd3) ? 3'b011 : {1'b1, w}, addr, 0);
    end
  endtask

  task automatic test_sign_ext();
    logic [63:0] addr;
    logic [63:0] data;
    for (int w = 0; w < 3; w++) begin
      for (int s = 0; s < 2; s++) begin
        addr = rand_ram_addr(w);
        data = rand_bits(64);
        // force the top stored bit
        data[(8 << w) - 1] = s[0];
        ram_store(w, addr, data);
        ram_load({1'b0, 2'(w)}, addr, 0);
        ram_load({1'b1, 2'(w)}, addr, 0);
      end
    end
  endtask

  task automatic test_device();
    logic [63:0] rd;
    logic [63:0] t1;
    logic [63:0] data;
    logic        er;
    int          c1;
    data = rand_bits(64);
    run_op(mem_pkg::MEM_ACTION_STORE, 3'b011, bus_pkg::DEV_BASE | 64'h8, data, 4, 0, rd, er);
    run_op(mem_pkg::MEM_ACTION_LOAD, 3'b011, bus_pkg::DEV_BASE | 64'h8, '0, 4, 0, rd, er);
    check_data("o_rdata scratch", rd, data);
    check_err("o_bus_err", er, 1'b0);
    // timer delta equals edges between the two issues
    run_op(mem_pkg::MEM_ACTION_LOAD, 3'b011, bus_pkg::DEV_BASE, '0, 4, 0, t1, er);
    c1 = issue_cyc;
    repeat (3 + rand_bits(3)) @(posedge clk);
    run_op(mem_pkg::MEM_ACTION_LOAD, 3'b011, bus_pkg::DEV_BASE, '0, 4, 0, rd, er);
    check_data("timer delta", rd - t1, 64'(issue_cyc - c1));
  endtask

  task automatic test_unmapped();
    logic [63:0] rd;
    logic [63:0] addr;
    logic        er;
    run_op(mem_pkg::MEM_ACTION_LOAD, 3'b011, 64'h1000_0000, '0, 3, 0, rd, er);
    check_err("o_bus_err unmapped", er, 1'b1);
    check_data("o_rdata unmapped", rd, '0);
    addr = rand_ram_addr(2'd3);
    ram_store(2'd3, addr, rand_bits(64));
    ram_load(3'b011, addr, 0);
  endtask

  task automatic test_backpressure();
    logic [63:0] addr;
    addr = rand_ram_addr(2'd2);
    ram_store(2'd2, addr, rand_bits(64));
    ram_load(3'b010, addr, 8);
  endtask

  initial begin
    rst            = 1'b1;
    i_executed_req = 1'b0;
    i_memaction    = mem_pkg::MEM_ACTION_NONE;
    i_funct3       = '0;
    i_addr         = '0;
    i_wdata        = '0;
    i_memoryed_ack = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_none();
    test_ram_random();
    test_sign_ext();
    test_device();
    test_unmapped();
    test_backpressure();
    repeat (2) @(posedge clk);
    $display("errors: data %0d, flag %0d, latency %0d, timeout %0d",
             data_errs, bit_errs, lat_errs, timeouts);
    if (data_errs + bit_errs + lat_errs + timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/mem_subsys_top.sv ====
/* Memory subsystem top: memory stage, bus router, data RAM and device regs.
   Plain ports toward execute and writeback. */
module mem_subsys_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_executed_req,
  input  logic [1:0]                  i_memaction,
  input  logic [2:0]                  i_funct3,
  input  logic [bus_pkg::ADDR_W-1:0]  i_addr,
  input  logic [mem_pkg::XLEN-1:0]    i_wdata,
  input  logic                        i_memoryed_ack,
  output logic                        o_memoryed_req,
  output logic [mem_pkg::XLEN-1:0]    o_rdata,
  output logic                        o_bus_err
);

  // stage to router
  dbus_if cpu_bus ();
  // router to targets
  dbus_if ram_bus ();
  dbus_if dev_bus ();

  mem_stage u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .i_memaction    (mem_pkg::mem_action_t'(i_memaction)),
    .i_funct3       (mem_pkg::funct3_t'(i_funct3)),
    .i_addr         (i_addr),
    .i_wdata        (i_wdata),
    .i_memoryed_ack (i_memoryed_ack),
    .o_memoryed_req (o_memoryed_req),
    .o_rdata        (o_rdata),
    .o_bus_err      (o_bus_err),
    .bus            (cpu_bus.initiator)
  );

  dbus_router u_dbus_router (
    .clk (clk),
    .rst (rst),
    .cpu (cpu_bus.target),
    .ram (ram_bus.initiator),
    .dev (dev_bus.initiator)
  );

  data_ram u_data_ram (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.target)
  );

  dev_regs u_dev_regs (
    .clk (clk),
    .rst (rst),
    .bus (dev_bus.target)
  );

endmodule

// ==== hdl/dbus_router.sv ====
/* Data bus router: decodes the address, forwards req to one target and
   returns its response; unmapped addresses get a local error ack. */
module dbus_router (
  input  logic      clk,
  input  logic      rst,
  dbus_if.target    cpu,
  dbus_if.initiator ram,
  dbus_if.initiator dev
);

  logic sel_ram;
  logic sel_dev;
  logic miss;
  logic err_ack;

  // region decode against base and mask
  assign sel_ram = (cpu.addr & ~bus_pkg::RAM_MASK) == bus_pkg::RAM_BASE;
  assign sel_dev = (cpu.addr & ~bus_pkg::DEV_MASK) == bus_pkg::DEV_BASE;
  assign miss    = ~sel_ram & ~sel_dev;

  // req goes to the selected target only
  assign ram.req   = cpu.req & sel_ram;
  assign ram.op    = cpu.op;
  assign ram.addr  = cpu.addr;
  assign ram.bytes = cpu.bytes;
  assign ram.wdata = cpu.wdata;

  assign dev.req   = cpu.req & sel_dev;
  assign dev.op    = cpu.op;
  assign dev.addr  = cpu.addr;
  assign dev.bytes = cpu.bytes;
  assign dev.wdata = cpu.wdata;

  // local ack for unmapped addresses, one cycle after req
  always_ff @(posedge clk) begin
    if (rst) begin
      err_ack <= 1'b0;
    end else begin
      err_ack <= cpu.req & miss & ~err_ack;
    end
  end

  // response mux
  always_comb begin
    if (sel_ram) begin
      cpu.ack   = ram.ack;
      cpu.rdata = ram.rdata;
      cpu.err   = ram.err;
    end else if (sel_dev) begin
      cpu.ack   = dev.ack;
      cpu.rdata = dev.rdata;
      cpu.err   = dev.err;
    end else begin
      // unmapped reads zero with error set
      cpu.ack   = err_ack;
      cpu.rdata = '0;
      cpu.err   = 1'b1;
    end
  end

endmodule

// ==== hdl/dev_regs.sv ====
/* Device register target: free-running cycle timer and a scratch register.
   Acks two cycles after req; data is sampled on the first cycle. */
module dev_regs (
  input  logic   clk,
  input  logic   rst,
  dbus_if.target bus
);

  logic [mem_pkg::XLEN-1:0] timer;
  logic [mem_pkg::XLEN-1:0] scratch;
  logic                     pend;
  logic                     take;
  logic                     hit_timer;
  logic                     hit_scratch;
  logic [2:0]               ofs;

  // decode on doubleword offset, low bits pick the lane
  assign hit_timer   = bus.addr[bus_pkg::DEV_OFS_W-1:3] ==
                       bus_pkg::DEV_TIMER_OFS[bus_pkg::DEV_OFS_W-1:3];
  assign hit_scratch = bus.addr[bus_pkg::DEV_OFS_W-1:3] ==
                       bus_pkg::DEV_SCRATCH_OFS[bus_pkg::DEV_OFS_W-1:3];
  assign ofs         = bus.addr[2:0];

  // new request, neither stage busy
  assign take = bus.req & ~pend & ~bus.ack;

  // control and registers
  always_ff @(posedge clk) begin
    if (rst) begin
      timer   <= '0;
      scratch <= '0;
      pend    <= 1'b0;
      bus.ack <= 1'b0;
    end else begin
      timer   <= timer + 1'b1;
      // two-stage pending gives ack at req + 2
      pend    <= take;
      bus.ack <= pend;
      // timer is read only
      if (take && bus.op == mem_pkg::REQ_WRITE && hit_scratch) begin
        scratch <= bus_pkg::lane_merge(scratch, bus.wdata, ofs, bus.bytes);
      end
    end
  end

  // read data captured on the first stage, held through ack
  always_ff @(posedge clk) begin
    if (take) begin
      if (bus.op == mem_pkg::REQ_WRITE) begin
        bus.rdata <= '0;
      end else if (hit_timer) begin
        bus.rdata <= bus_pkg::lane_extract(timer, ofs, bus.bytes);
      end else if (hit_scratch) begin
        bus.rdata <= bus_pkg::lane_extract(scratch, ofs, bus.bytes);
      end else begin
        // unknown offset
        bus.rdata <= '0;
      end
    end
  end

  assign bus.err = 1'b0;

endmodule

// ==== hdl/data_ram.sv ====
/* Data RAM target on the bus, doubleword array with byte-lane writes.
   Acks one cycle after req; never reports an error. */
module data_ram (
  input  logic   clk,
  input  logic   rst,
  dbus_if.target bus
);

  logic [mem_pkg::XLEN-1:0]      mem [bus_pkg::RAM_WORDS];
  logic [bus_pkg::RAM_IDX_W-1:0] idx;
  logic [2:0]                    ofs;
  logic                          take;

  // doubleword index, bits above the array wrap
  assign idx  = bus.addr[3 +: bus_pkg::RAM_IDX_W];
  // byte lane of the low byte
  assign ofs  = bus.addr[2:0];

  // first cycle of a request, ack not yet given
  assign take = bus.req & ~bus.ack;

  // one-cycle ack per request
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= take;
    end
  end

  // array access on the request cycle
  always_ff @(posedge clk) begin
    if (take) begin
      if (bus.op == mem_pkg::REQ_WRITE) begin
        // only the addressed lanes change
        mem[idx]  <= bus_pkg::lane_merge(mem[idx], bus.wdata, ofs, bus.bytes);
        bus.rdata <= '0;
      end else begin
        bus.rdata <= bus_pkg::lane_extract(mem[idx], ofs, bus.bytes);
      end
    end
  end

  // every RAM address is valid
  assign bus.err = 1'b0;

endmodule

// ==== hdl/mem_stage.sv ====
/* Memory-access stage: takes one op from execute, runs one data bus request
   and presents the extended result to writeback until it is acknowledged. */
module mem_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_executed_req,
  input  mem_pkg::mem_action_t        i_memaction,
  input  mem_pkg::funct3_t            i_funct3,
  input  logic [bus_pkg::ADDR_W-1:0]  i_addr,
  input  logic [mem_pkg::XLEN-1:0]    i_wdata,
  input  logic                        i_memoryed_ack,
  output logic                        o_memoryed_req,
  output logic [mem_pkg::XLEN-1:0]    o_rdata,
  output logic                        o_bus_err,
  dbus_if.initiator                   bus
);

  bus_pkg::bytes_t req_bytes;
  logic            wait_ack;
  logic            accept;
  logic            hs;
  // kept from the accepted op for the response
  logic            is_load;
  logic            zero_ext;

  // sign or zero extend from the access width
  function automatic logic [mem_pkg::XLEN-1:0] extend(
    logic [mem_pkg::XLEN-1:0] data,
    bus_pkg::bytes_t          nb,
    logic                     uns
  );
    logic [mem_pkg::XLEN-1:0] mask;
    logic                     sign;
    mask = bus_pkg::width_mask(nb);
    case (nb)
      3'd0:    sign = data[7];
      3'd1:    sign = data[15];
      3'd3:    sign = data[31];
      default: sign = data[63];
    endcase
    if (uns)
      return data & mask;
    return (data & mask) | (~mask & {mem_pkg::XLEN{sign}});
  endfunction

  // funct3 width to bytes minus one
  always_comb begin
    case (i_funct3[1:0])
      mem_pkg::F3_BYTE:   req_bytes = 3'd0;
      mem_pkg::F3_HALF:   req_bytes = 3'd1;
      mem_pkg::F3_WORD:   req_bytes = 3'd3;
      mem_pkg::F3_DOUBLE: req_bytes = 3'd7;
      default:            req_bytes = 3'd0;
    endcase
  end

  // new op only when idle and writeback has taken the last one
  assign accept = i_executed_req & ~o_memoryed_req & ~wait_ack;
  assign hs     = wait_ack & bus.req & bus.ack;

  // control: bus req, wait flag, writeback req
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.req        <= 1'b0;
      wait_ack       <= 1'b0;
      o_memoryed_req <= 1'b0;
    end else if (accept) begin
      if (i_memaction == mem_pkg::MEM_ACTION_NONE) begin
        // nothing to access, straight to writeback
        o_memoryed_req <= 1'b1;
      end else begin
        bus.req  <= 1'b1;
        wait_ack <= 1'b1;
      end
    end else if (hs) begin
      bus.req        <= 1'b0;
      wait_ack       <= 1'b0;
      o_memoryed_req <= 1'b1;
    end else if (i_memoryed_ack) begin
      o_memoryed_req <= 1'b0;
    end
  end

  // request fields and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      bus.op    <= (i_memaction == mem_pkg::MEM_ACTION_STORE) ?
                   mem_pkg::REQ_WRITE : mem_pkg::REQ_READ;
      bus.addr  <= i_addr;
      bus.bytes <= req_bytes;
      bus.wdata <= i_wdata;
      is_load   <= (i_memaction == mem_pkg::MEM_ACTION_LOAD);
      zero_ext  <= i_funct3[mem_pkg::F3_UNSIGNED_BIT];
      // none op returns clean zero
      o_rdata   <= '0;
      o_bus_err <= 1'b0;
    end else if (hs) begin
      // stores report zero data
      o_rdata   <= is_load ? extend(bus.rdata, bus.bytes, zero_ext) : '0;
      o_bus_err <= bus.err;
    end
  end

endmodule

// ==== hdl/dbus_if.sv ====
/* Data bus between the memory stage, the router and the targets.
   Level req/ack: req held until ack is sampled, ack high for one cycle. */
interface dbus_if;

  // request side
  logic                        req;
  logic                        op;
  logic [bus_pkg::ADDR_W-1:0]  addr;
  bus_pkg::bytes_t             bytes;
  // right-aligned store data
  logic [mem_pkg::XLEN-1:0]    wdata;

  // response side
  logic                        ack;
  // right-aligned load data
  logic [mem_pkg::XLEN-1:0]    rdata;
  logic                        err;

  modport initiator (
    output req, op, addr, bytes, wdata,
    input  ack, rdata, err
  );

  modport target (
    input  req, op, addr, bytes, wdata,
    output ack, rdata, err
  );

endinterface

// ==== hdl/bus_pkg.sv ====
/* Data bus address map, target sizes and byte-lane helpers.
   Used by the router, both bus targets and the memory stage. */
package bus_pkg;

  localparam int ADDR_W = 64;

  // memory region, 256 MB in the map
  localparam logic [ADDR_W-1:0] RAM_BASE = 64'h0000_0000_8000_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK = 64'h0000_0000_0FFF_FFFF;

  // doublewords actually built, upper address bits wrap
  localparam int RAM_WORDS = 512;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);

  // device region, 4 KB
  localparam logic [ADDR_W-1:0] DEV_BASE = 64'h0000_0000_2000_0000;
  localparam logic [ADDR_W-1:0] DEV_MASK = 64'h0000_0000_0000_0FFF;
  localparam int DEV_OFS_W = 12;

  // device register offsets
  localparam logic [DEV_OFS_W-1:0] DEV_TIMER_OFS   = 12'h000;
  localparam logic [DEV_OFS_W-1:0] DEV_SCRATCH_OFS = 12'h008;

  // access size as bytes minus one: 0, 1, 3 or 7
  typedef logic [2:0] bytes_t;

  // mask of the low nb+1 bytes of a right-aligned value
  function automatic logic [mem_pkg::XLEN-1:0] width_mask(bytes_t nb);
    return {mem_pkg::XLEN{1'b1}} >> {3'd7 - nb, 3'b000};
  endfunction

  // place right-aligned data into the lanes starting at ofs
  function automatic logic [mem_pkg::XLEN-1:0] lane_merge(
    logic [mem_pkg::XLEN-1:0] old_word,
    logic [mem_pkg::XLEN-1:0] data,
    logic [2:0]               ofs,
    bytes_t                   nb
  );
    logic [mem_pkg::XLEN-1:0] lane_mask;
    lane_mask = width_mask(nb) << {ofs, 3'b000};
    return (old_word & ~lane_mask) | ((data << {ofs, 3'b000}) & lane_mask);
  endfunction

  // pull the addressed lanes back down to bit 0
  function automatic logic [mem_pkg::XLEN-1:0] lane_extract(
    logic [mem_pkg::XLEN-1:0] word,
    logic [2:0]               ofs,
    bytes_t                   nb
  );
    return (word >> {ofs, 3'b000}) & width_mask(nb);
  endfunction

endpackage

// ==== hdl/mem_pkg.sv ====
/* Memory-stage codes shared by execute, the memory stage and the testbench.
   Operation codes, funct3 width and extension fields, and bus op codes. */
package mem_pkg;

  // datapath width of the core
  localparam int XLEN = 64;

  // operation handed over from execute
  typedef enum logic [1:0] {
    MEM_ACTION_NONE  = 2'b00,
    MEM_ACTION_LOAD  = 2'b01,
    MEM_ACTION_STORE = 2'b10
  } mem_action_t;

  // bus op, one bit
  localparam logic REQ_READ  = 1'b0;
  localparam logic REQ_WRITE = 1'b1;

  // funct3 of loads and stores
  typedef logic [2:0] funct3_t;

  // width field, funct3[1:0]
  localparam logic [1:0] F3_BYTE   = 2'b00;
  localparam logic [1:0] F3_HALF   = 2'b01;
  localparam logic [1:0] F3_WORD   = 2'b10;
  localparam logic [1:0] F3_DOUBLE = 2'b11;

  // bit 2 set selects zero extension (lbu, lhu, lwu)
  localparam int F3_UNSIGNED_BIT = 2;

endpackage
